// ==== flist.f ====
+incdir+testbench
src/llc_pkg.sv
src/llc_tag_store.sv
src/llc_data_store.sv
src/llc_ctrl.sv
src/llc_top.sv
testbench/llc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f flist.f --top-module llc_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vllc_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi

// ==== src/llc_ctrl.sv ====
`default_nettype none

module llc_ctrl #(
    parameter int LLC_WAYS = llc_pkg::DEFAULT_WAYS,
    localparam int WAY_BITS = (LLC_WAYS > 1) ? $clog2(LLC_WAYS) : 1
) (
    input  wire logic                              clk,
    input  wire logic                              rst,

    // requester
    input  wire logic                              req_valid_i,
    input  wire logic                              req_write_i,
    input  wire llc_pkg::line_addr_t               req_addr_i,
    input  wire llc_pkg::offset_t                  req_word_i,
    input  wire llc_pkg::word_t                    req_data_i,
    output logic                                   req_ready_o,
    output logic                                   rsp_valid_o,
    output llc_pkg::word_t                         rsp_data_o,
    input  wire logic                              rsp_ready_i,

    // memory
    output logic                                   mem_req_valid_o,
    output logic                                   mem_req_write_o,
    output logic [llc_pkg::LINE_ADDR_BITS-1:0]     mem_req_addr_o,
    output llc_pkg::line_t                         mem_req_line_o,
    input  wire logic                              mem_req_ready_i,
    input  wire logic                              mem_rsp_valid_i,
    input  wire llc_pkg::line_t                    mem_rsp_line_i,
    output logic                                   mem_rsp_ready_o,

    // stores
    output logic                                   rd_en_o,
    output llc_pkg::set_t                          set_o,
    output llc_pkg::tag_t                          tag_o,
    output logic                                   wr_en_o,
    output logic [WAY_BITS-1:0]                    wr_way_o,
    output logic                                   wr_dirty_o,
    output logic                                   advance_evict_o,
    output llc_pkg::line_t                         wr_line_o,
    input  wire logic                              hit_i,
    input  wire logic [WAY_BITS-1:0]               hit_way_i,
    input  wire logic [WAY_BITS-1:0]               victim_way_i,
    input  wire llc_pkg::tag_t                     victim_tag_i,
    input  wire logic                              victim_dirty_i,
    input  wire llc_pkg::line_t [LLC_WAYS-1:0]     rd_lines_i
);

    localparam logic [2:0] DECODE  = 3'b000;
    localparam logic [2:0] READ    = 3'b001;
    localparam logic [2:0] LOOKUP  = 3'b011;
    localparam logic [2:0] PROCESS = 3'b010;
    localparam logic [2:0] UPDATE  = 3'b110;

    // steps inside process
    localparam logic [1:0] P_WB    = 2'd0;
    localparam logic [1:0] P_FETCH = 2'd1;
    localparam logic [1:0] P_WAIT  = 2'd2;
    localparam logic [1:0] P_RSP   = 2'd3;

    logic [2:0] state, next_state;
    logic [1:0] phase;
    logic       process_done;

    logic                write_q;
    llc_pkg::line_addr_t addr_q;
    llc_pkg::offset_t    word_q;
    llc_pkg::word_t      data_q;
    llc_pkg::line_t      line_buf;
    llc_pkg::line_addr_t victim_addr;
    logic [WAY_BITS-1:0] way;

    function automatic llc_pkg::line_t merge_word(
        input llc_pkg::line_t   line,
        input llc_pkg::offset_t ofs,
        input llc_pkg::word_t   data,
        input logic             en
    );
        llc_pkg::line_t res;
        res = line;
        if (en) begin
            res[ofs] = data;
        end
        return res;
    endfunction

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= DECODE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            DECODE:  if (req_valid_i) next_state = READ;
            READ:    next_state = LOOKUP;
            LOOKUP:  next_state = PROCESS;
            PROCESS: if (process_done) next_state = UPDATE;
            UPDATE:  next_state = DECODE;
            default: next_state = DECODE;
        endcase
    end

    assign req_ready_o  = (state == DECODE);
    assign process_done = (state == PROCESS) && (phase == P_RSP) && rsp_ready_i;

    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            write_q <= req_write_i;
            addr_q  <= req_addr_i;
            word_q  <= req_word_i;
            data_q  <= req_data_i;
        end
    end

    // lookup results stay put until the next read
    assign way = hit_i ? hit_way_i : victim_way_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            phase <= P_RSP;
        end else if (state == LOOKUP) begin
            if (hit_i) begin
                phase <= P_RSP;
            end else if (victim_dirty_i) begin
                phase <= P_WB;
            end else begin
                phase <= P_FETCH;
            end
        end else if (state == PROCESS) begin
            case (phase)
                P_WB:    if (mem_req_ready_i) phase <= P_FETCH;
                P_FETCH: if (mem_req_ready_i) phase <= P_WAIT;
                P_WAIT:  if (mem_rsp_valid_i) phase <= P_RSP;
                default: phase <= P_RSP;
            endcase
        end
    end

    // hit line merged right away, victim line held for write-back
    always_ff @(posedge clk) begin
        if (state == LOOKUP) begin
            line_buf <= merge_word(rd_lines_i[way], word_q, data_q, write_q & hit_i);
        end else if (mem_rsp_valid_i && mem_rsp_ready_o) begin
            line_buf <= merge_word(mem_rsp_line_i, word_q, data_q, write_q);
        end
    end

    always_comb begin
        victim_addr.fields.tag = victim_tag_i;
        victim_addr.fields.set = addr_q.fields.set;
    end

    assign mem_req_valid_o = (state == PROCESS) && ((phase == P_WB) || (phase == P_FETCH));
    assign mem_req_write_o = (phase == P_WB);
    assign mem_req_addr_o  = (phase == P_WB) ? victim_addr.raw : addr_q.raw;
    assign mem_req_line_o  = line_buf;
    assign mem_rsp_ready_o = (state == PROCESS) && (phase == P_WAIT);

    assign rsp_valid_o = (state == PROCESS) && (phase == P_RSP);
    assign rsp_data_o  = line_buf[word_q];   // written word on writes

    assign rd_en_o = (state == READ);
    assign set_o   = addr_q.fields.set;
    assign tag_o   = addr_q.fields.tag;

    // read hit leaves tag and dirty untouched
    assign wr_en_o         = (state == UPDATE) && (!hit_i || write_q);
    assign wr_way_o        = way;
    assign wr_dirty_o      = write_q;
    assign wr_line_o       = line_buf;
    assign advance_evict_o = (state == UPDATE) && !hit_i;   // only after a fill

endmodule

`default_nettype wire

// ==== src/llc_data_store.sv ====
`default_nettype none

module llc_data_store #(
    parameter int LLC_WAYS = llc_pkg::DEFAULT_WAYS,
    localparam int WAY_BITS = (LLC_WAYS > 1) ? $clog2(LLC_WAYS) : 1
) (
    input  wire logic                       clk,
    input  wire logic                       rst,

    input  wire logic                       rd_en_i,
    input  wire llc_pkg::set_t              set_i,
    output llc_pkg::line_t [LLC_WAYS-1:0]   rd_lines_o,

    input  wire logic                       wr_en_i,
    input  wire logic [WAY_BITS-1:0]        wr_way_i,
    input  wire llc_pkg::line_t             wr_line_i
);

    localparam int SETS = 2 ** llc_pkg::SET_BITS;

    llc_pkg::line_t lines [SETS][LLC_WAYS];

    // whole set comes out one cycle after the read
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_lines_o <= '0;
        end else if (rd_en_i) begin
            for (int w = 0; w < LLC_WAYS; w++) begin
                rd_lines_o[w] <= lines[set_i][w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            lines[set_i][wr_way_i] <= wr_line_i;   // single way per write
        end
    end

endmodule

`default_nettype wire

// ==== src/llc_pkg.sv ====
`default_nettype none

package llc_pkg;

    localparam int WORD_BITS      = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int OFFSET_BITS    = 2;   // log2 of words per line
    localparam int SET_BITS       = 4;   // 16 sets
    localparam int TAG_BITS       = 12;
    localparam int LINE_ADDR_BITS = TAG_BITS + SET_BITS;

    localparam int DEFAULT_WAYS = 4;

    typedef logic [WORD_BITS-1:0] word_t;

    // word 0 sits in the low bits
    typedef word_t [WORDS_PER_LINE-1:0] line_t;

    typedef logic [TAG_BITS-1:0]    tag_t;
    typedef logic [SET_BITS-1:0]    set_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;

    typedef struct packed {
        tag_t tag;   // upper bits
        set_t set;   // lower bits
    } line_fields_t;

    // raw view goes out to memory, fields view indexes the cache
    typedef union packed {
        logic [LINE_ADDR_BITS-1:0] raw;
        line_fields_t              fields;
    } line_addr_t;

endpackage

`default_nettype wire

// ==== src/llc_tag_store.sv ====
`default_nettype none

module llc_tag_store #(
    parameter int LLC_WAYS = llc_pkg::DEFAULT_WAYS,
    localparam int WAY_BITS = (LLC_WAYS > 1) ? $clog2(LLC_WAYS) : 1
) (
    input  wire logic                clk,
    input  wire logic                rst,

    input  wire logic                rd_en_i,
    input  wire llc_pkg::set_t       set_i,
    input  wire llc_pkg::tag_t       tag_i,

    output logic                     hit_o,
    output logic [WAY_BITS-1:0]      hit_way_o,
    output logic [WAY_BITS-1:0]      victim_way_o,
    output llc_pkg::tag_t            victim_tag_o,
    output logic                     victim_dirty_o,

    input  wire logic                wr_en_i,
    input  wire logic [WAY_BITS-1:0] wr_way_i,
    input  wire llc_pkg::tag_t       wr_tag_i,
    input  wire logic                wr_dirty_i,
    input  wire logic                advance_evict_i
);

    localparam int SETS = 2 ** llc_pkg::SET_BITS;

    llc_pkg::tag_t       tags      [SETS][LLC_WAYS];
    logic [LLC_WAYS-1:0] valid     [SETS];
    logic [LLC_WAYS-1:0] dirty     [SETS];
    logic [WAY_BITS-1:0] evict_ptr [SETS];

    logic                hit_c;
    logic [WAY_BITS-1:0] hit_way_c;
    logic [WAY_BITS-1:0] ptr_cur;

    assign ptr_cur = evict_ptr[set_i];

    // compare against every valid way of the set
    always_comb begin
        hit_c     = 1'b0;
        hit_way_c = '0;
        for (int w = 0; w < LLC_WAYS; w++) begin
            if (valid[set_i][w] && (tags[set_i][w] == tag_i)) begin
                hit_c     = 1'b1;
                hit_way_c = WAY_BITS'(w);
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            hit_o          <= 1'b0;
            hit_way_o      <= '0;
            victim_way_o   <= '0;
            victim_tag_o   <= '0;
            victim_dirty_o <= 1'b0;
        end else if (rd_en_i) begin
            hit_o          <= hit_c;
            hit_way_o      <= hit_way_c;
            victim_way_o   <= ptr_cur;
            victim_tag_o   <= tags[set_i][ptr_cur];
            victim_dirty_o <= valid[set_i][ptr_cur] & dirty[set_i][ptr_cur];
        end
    end

    // tags only mean something where valid is set
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tags[set_i][wr_way_i] <= wr_tag_i;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < SETS; s++) begin
                valid[s]     <= '0;
                dirty[s]     <= '0;
                evict_ptr[s] <= '0;
            end
        end else begin
            if (wr_en_i) begin
                valid[set_i][wr_way_i] <= 1'b1;
                dirty[set_i][wr_way_i] <= wr_dirty_i;
            end
            if (advance_evict_i) begin
                if (ptr_cur == WAY_BITS'(LLC_WAYS - 1)) begin
                    evict_ptr[set_i] <= '0;
                end else begin
                    evict_ptr[set_i] <= ptr_cur + 1'b1;   // round robin
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/llc_top.sv ====
`default_nettype none

module llc_top #(
    parameter int LLC_WAYS = llc_pkg::DEFAULT_WAYS
) (
    input  wire logic                          clk,
    input  wire logic                          rst,

    input  wire logic                          req_valid_i,
    input  wire logic                          req_write_i,
    input  wire llc_pkg::line_addr_t           req_addr_i,
    input  wire llc_pkg::offset_t              req_word_i,
    input  wire llc_pkg::word_t                req_data_i,
    output logic                               req_ready_o,
    output logic                               rsp_valid_o,
    output llc_pkg::word_t                     rsp_data_o,
    input  wire logic                          rsp_ready_i,

    output logic                               mem_req_valid_o,
    output logic                               mem_req_write_o,
    output logic [llc_pkg::LINE_ADDR_BITS-1:0] mem_req_addr_o,
    output llc_pkg::line_t                     mem_req_line_o,
    input  wire logic                          mem_req_ready_i,
    input  wire logic                          mem_rsp_valid_i,
    input  wire llc_pkg::line_t                mem_rsp_line_i,
    output logic                               mem_rsp_ready_o
);

    localparam int WAY_BITS = (LLC_WAYS > 1) ? $clog2(LLC_WAYS) : 1;

    logic                          rd_en;
    llc_pkg::set_t                 set;
    llc_pkg::tag_t                 tag;
    logic                          wr_en;
    logic [WAY_BITS-1:0]           wr_way;
    logic                          wr_dirty;
    logic                          advance_evict;
    llc_pkg::line_t                wr_line;
    logic                          hit;
    logic [WAY_BITS-1:0]           hit_way;
    logic [WAY_BITS-1:0]           victim_way;
    llc_pkg::tag_t                 victim_tag;
    logic                          victim_dirty;
    llc_pkg::line_t [LLC_WAYS-1:0] rd_lines;

    llc_tag_store #(.LLC_WAYS(LLC_WAYS)) tag_store_inst (
        .clk, .rst,
        .rd_en_i         (rd_en),
        .set_i           (set),
        .tag_i           (tag),
        .hit_o           (hit),
        .hit_way_o       (hit_way),
        .victim_way_o    (victim_way),
        .victim_tag_o    (victim_tag),
        .victim_dirty_o  (victim_dirty),
        .wr_en_i         (wr_en),
        .wr_way_i        (wr_way),
        .wr_tag_i        (tag),   // lookup tag is the one written
        .wr_dirty_i      (wr_dirty),
        .advance_evict_i (advance_evict)
    );

    llc_data_store #(.LLC_WAYS(LLC_WAYS)) data_store_inst (
        .clk, .rst,
        .rd_en_i    (rd_en),
        .set_i      (set),
        .rd_lines_o (rd_lines),
        .wr_en_i    (wr_en),
        .wr_way_i   (wr_way),
        .wr_line_i  (wr_line)
    );

    llc_ctrl #(.LLC_WAYS(LLC_WAYS)) ctrl_inst (
        .clk, .rst,
        .req_valid_i, .req_write_i, .req_addr_i, .req_word_i, .req_data_i, .req_ready_o,
        .rsp_valid_o, .rsp_data_o, .rsp_ready_i,
        .mem_req_valid_o, .mem_req_write_o, .mem_req_addr_o, .mem_req_line_o,
        .mem_req_ready_i, .mem_rsp_valid_i, .mem_rsp_line_i, .mem_rsp_ready_o,
        .rd_en_o (rd_en), .set_o (set), .tag_o (tag),
        .wr_en_o (wr_en), .wr_way_o (wr_way), .wr_dirty_o (wr_dirty),
        .advance_evict_o (advance_evict), .wr_line_o (wr_line),
        .hit_i (hit), .hit_way_i (hit_way), .victim_way_i (victim_way),
        .victim_tag_i (victim_tag), .victim_dirty_i (victim_dirty), .rd_lines_i (rd_lines)
    );

endmodule

`default_nettype wire

// ==== testbench/llc_tb_model.svh ====
`ifndef LLC_TB_MODEL_SVH
`define LLC_TB_MODEL_SVH

// expected state of the cache and of memory, kept apart from the DUT
localparam int MODEL_SETS = 16;

llc_pkg::word_t shadow_mem [int];   // key is {line address, word index}
logic [11:0]    m_tag      [MODEL_SETS][TB_WAYS];
logic           m_valid    [MODEL_SETS][TB_WAYS];
logic           m_dirty    [MODEL_SETS][TB_WAYS];
int             m_ptr      [MODEL_SETS];

// initial memory contents, every bit of the line address shows up
function automatic llc_pkg::word_t pattern_word(input logic [15:0] la, input logic [1:0] idx);
    return {la ^ 16'hc3a5, la[7:0], 6'h2b, idx};
endfunction

function automatic llc_pkg::word_t expected_read(input logic [15:0] la, input logic [1:0] idx);
    int key;
    key = int'({la, idx});
    if (shadow_mem.exists(key)) begin
        return shadow_mem[key];
    end
    return pattern_word(la, idx);
endfunction

function automatic void shadow_write(input logic [15:0] la, input logic [1:0] idx,
                                     input llc_pkg::word_t data);
    shadow_mem[int'({la, idx})] = data;
endfunction

function automatic llc_pkg::line_t shadow_line(input logic [15:0] la);
    llc_pkg::line_t l;
    for (int i = 0; i < 4; i++) begin
        l[i] = expected_read(la, 2'(i));
    end
    return l;
endfunction

function automatic void model_reset();
    for (int s = 0; s < MODEL_SETS; s++) begin
        m_ptr[s] = 0;
        for (int w = 0; w < TB_WAYS; w++) begin
            m_tag[s][w]   = '0;
            m_valid[s][w] = 1'b0;
            m_dirty[s][w] = 1'b0;
        end
    end
endfunction

// hit or miss, and on a miss the round-robin victim
function automatic void model_access(input logic [15:0] la, input logic wr, output logic hit,
                                     output logic wb, output logic [15:0] victim_la);
    int s;
    int v;
    s         = int'(la[3:0]);
    hit       = 1'b0;
    wb        = 1'b0;
    victim_la = '0;
    for (int w = 0; w < TB_WAYS; w++) begin
        if (m_valid[s][w] && m_tag[s][w] == la[15:4]) begin
            hit = 1'b1;
            if (wr) m_dirty[s][w] = 1'b1;
        end
    end
    if (!hit) begin
        v         = m_ptr[s];
        wb        = m_valid[s][v] & m_dirty[s][v];
        victim_la = {m_tag[s][v], la[3:0]};
        m_tag[s][v]   = la[15:4];
        m_valid[s][v] = 1'b1;
        m_dirty[s][v] = wr;
        m_ptr[s]      = (v + 1) % TB_WAYS;
    end
endfunction

`endif

// ==== testbench/llc_tb.sv ====
`default_nettype none

module llc_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TB_WAYS    = 4;
    localparam int WAIT_LIMIT = 200;
    localparam int IDLE_LIMIT = 20000;

    logic                clk;
    logic                rst;
    logic                req_valid_i;
    logic                req_write_i;
    llc_pkg::line_addr_t req_addr_i;
    llc_pkg::offset_t    req_word_i;
    llc_pkg::word_t      req_data_i;
    logic                req_ready_o;
    logic                rsp_valid_o;
    llc_pkg::word_t      rsp_data_o;
    logic                rsp_ready_i;
    logic                mem_req_valid_o;
    logic                mem_req_write_o;
    logic [15:0]         mem_req_addr_o;
    llc_pkg::line_t      mem_req_line_o;
    logic                mem_req_ready_i;
    logic                mem_rsp_valid_i;
    llc_pkg::line_t      mem_rsp_line_i;
    logic                mem_rsp_ready_o;

    `include "llc_tb_model.svh"

    llc_pkg::line_t mem_lines [int];   // memory behind the cache
    llc_pkg::word_t exp_rsp [$];
    logic           exp_mem_write [$];
    logic [15:0]    exp_mem_addr [$];
    llc_pkg::line_t exp_mem_line [$];
    int             rsp_count   = 0;
    int             fetch_count = 0;
    int             wb_count    = 0;
    logic           random_gaps = 1'b0;

    llc_top #(.LLC_WAYS(TB_WAYS)) llc_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "check failed");
        end
    endtask

    function automatic llc_pkg::line_t memory_line(input logic [15:0] la);
        llc_pkg::line_t l;
        if (mem_lines.exists(int'(la))) begin
            return mem_lines[int'(la)];
        end
        for (int i = 0; i < 4; i++) begin
            l[i] = pattern_word(la, 2'(i));
        end
        return l;
    endfunction

    always @(posedge clk) begin
        rsp_ready_i <= random_gaps ? (2'($urandom_range(0, 3)) != 2'd0) : 1'b1;
    end

    // a transfer happens on the next rising edge
    always @(negedge clk) begin
        llc_pkg::word_t exp_word;
        if (rst && rsp_valid_o && rsp_ready_i) begin
            if (exp_rsp.size() == 0) begin
                report_failure("response seen with no request outstanding");
            end else begin
                exp_word = exp_rsp.pop_front();
                check_value(128'(rsp_data_o), 128'(exp_word), "response data");
                rsp_count++;
            end
        end
    end

    // memory responder
    initial begin
        int             n;
        logic           m_write;
        logic [15:0]    m_addr;
        llc_pkg::line_t m_line;
        n = 0;
        @(negedge clk);
        while (!rst) begin
            if (n == WAIT_LIMIT) report_failure("timeout waiting for reset release");
            n++;
            @(negedge clk);
        end
        forever begin
            n = 0;
            @(negedge clk);
            while (!mem_req_valid_o) begin
                if (n == IDLE_LIMIT) report_failure("timeout waiting for a memory request");
                n++;
                @(negedge clk);
            end
            m_write = mem_req_write_o;
            m_addr  = mem_req_addr_o;
            m_line  = mem_req_line_o;
            if (exp_mem_addr.size() == 0) begin
                report_failure("memory request that the model did not predict");
            end
            check_value(128'(m_write), 128'(exp_mem_write.pop_front()), "memory request kind");
            check_value(128'(m_addr), 128'(exp_mem_addr.pop_front()), "memory request address");
            if (m_write) begin
                check_value(m_line, exp_mem_line.pop_front(), "write-back line");
                wb_count++;
            end else begin
                m_line = exp_mem_line.pop_front();   // unused for fetches
                fetch_count++;
            end
            repeat ($urandom_range(0, 3)) @(posedge clk);
            @(posedge clk);
            mem_req_ready_i <= 1'b1;
            @(posedge clk);
            mem_req_ready_i <= 1'b0;
            if (m_write) begin
                mem_lines[int'(m_addr)] = m_line;
            end else begin
                repeat ($urandom_range(0, 3)) @(posedge clk);
                mem_rsp_valid_i <= 1'b1;
                mem_rsp_line_i  <= memory_line(m_addr);
                n = 0;
                @(negedge clk);
                while (!mem_rsp_ready_o) begin
                    if (n == WAIT_LIMIT) report_failure("timeout waiting for fetch acceptance");
                    n++;
                    @(negedge clk);
                end
                @(posedge clk);
                mem_rsp_valid_i <= 1'b0;
            end
        end
    end

    // expectations are queued before the request goes out
    task automatic do_access(input logic wr, input logic [15:0] la, input logic [1:0] idx,
                             input llc_pkg::word_t data, output logic hit, output logic wb);
        logic [15:0] victim_la;
        int          start;
        int          n;
        model_access(la, wr, hit, wb, victim_la);
        if (!hit) begin
            if (wb) begin
                exp_mem_write.push_back(1'b1);
                exp_mem_addr.push_back(victim_la);
                exp_mem_line.push_back(shadow_line(victim_la));
            end
            exp_mem_write.push_back(1'b0);
            exp_mem_addr.push_back(la);
            exp_mem_line.push_back('0);
        end
        if (wr) begin
            shadow_write(la, idx, data);
            exp_rsp.push_back(data);   // write echoes the word
        end else begin
            exp_rsp.push_back(expected_read(la, idx));
        end
        start = rsp_count;
        @(posedge clk);
        req_valid_i    <= 1'b1;
        req_write_i    <= wr;
        req_addr_i.raw <= la;
        req_word_i     <= idx;
        req_data_i     <= data;
        n = 0;
        @(negedge clk);
        while (!req_ready_o) begin
            if (n == WAIT_LIMIT) report_failure("timeout waiting for request acceptance");
            n++;
            @(negedge clk);
        end
        @(posedge clk);
        req_valid_i <= 1'b0;
        n = 0;
        while (rsp_count == start) begin
            if (n == WAIT_LIMIT) report_failure("timeout waiting for a response");
            n++;
            @(posedge clk);
        end
        check_value(128'(exp_mem_addr.size()), 128'(0), "memory requests left over");
    endtask

    initial begin
        logic hit;
        logic wb;
        int   f0;
        int   w0;
        void'($urandom(32'h3876_08f4));
        rst             <= 1'b0;
        req_valid_i     <= 1'b0;
        req_write_i     <= 1'b0;
        req_addr_i.raw  <= '0;
        req_word_i      <= '0;
        req_data_i      <= '0;
        rsp_ready_i     <= 1'b1;
        mem_req_ready_i <= 1'b0;
        mem_rsp_valid_i <= 1'b0;
        mem_rsp_line_i  <= '0;
        model_reset();
        repeat (8) @(posedge clk);
        rst <= 1'b1;

        // cold read fetches its line once
        f0 = fetch_count;
        do_access(1'b0, 16'h0010, 2'd1, '0, hit, wb);
        check_value(128'(hit), 128'(0), "cold read predicted miss");
        check_value(128'(fetch_count), 128'(f0 + 1), "fetches for cold read");

        // written word reads back and its neighbours keep the pattern
        do_access(1'b1, 16'h0010, 2'd2, 32'hdead_beef, hit, wb);
        do_access(1'b0, 16'h0010, 2'd2, '0, hit, wb);
        do_access(1'b0, 16'h0010, 2'd0, '0, hit, wb);
        do_access(1'b0, 16'h0010, 2'd3, '0, hit, wb);

        // resident line causes no memory traffic
        f0 = fetch_count;
        do_access(1'b0, 16'h0010, 2'd1, '0, hit, wb);
        check_value(128'(hit), 128'(1), "repeat access predicted hit");
        check_value(128'(fetch_count), 128'(f0), "fetches on a hit");

        // overfill set 0 so the dirty tag 1 goes first
        do_access(1'b0, 16'h0020, 2'd0, '0, hit, wb);
        do_access(1'b1, 16'h0030, 2'd1, 32'h1234_5678, hit, wb);
        do_access(1'b0, 16'h0040, 2'd2, '0, hit, wb);
        w0 = wb_count;
        do_access(1'b0, 16'h0050, 2'd3, '0, hit, wb);
        check_value(128'(wb), 128'(1), "dirty victim predicted");
        check_value(128'(wb_count), 128'(w0 + 1), "write-backs for dirty victim");
        do_access(1'b0, 16'h0060, 2'd0, '0, hit, wb);
        check_value(128'(wb_count), 128'(w0 + 1), "write-backs for clean victim");
        do_access(1'b0, 16'h0010, 2'd2, '0, hit, wb);   // comes back from memory

        // random mix with back-pressure
        random_gaps = 1'b1;
        for (int i = 0; i < 400; i++) begin
            repeat ($urandom_range(0, 2)) @(posedge clk);
            do_access(1'($urandom_range(0, 1)),
                      {12'($urandom_range(0, 5)), 4'($urandom_range(0, 1))},
                      2'($urandom_range(0, 3)), $urandom, hit, wb);
        end

        if (exp_rsp.size() == 0 && exp_mem_addr.size() == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            report_failure("expected traffic still pending at the end");
        end
    end

endmodule

`default_nettype wire
